// File: flow_xbar.f
source/flow_xbar_pkg.sv
source/flow_xbar_demux_stage.sv
source/flow_xbar_rr_arbiter.sv
source/flow_xbar_pop_port.sv
source/flow_xbar.sv
verification/flow_xbar_clock_gen.sv
verification/flow_xbar_checker.sv
verification/flow_xbar_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the flow crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f flow_xbar.f --top-module flow_xbar_tb -o flow_xbar_sim \
  && ./obj_dir/flow_xbar_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verification/flow_xbar_tb.sv
// top testbench for the flow crossbar with phase table, drivers and pop_ready modes
// latency and fairness checks, watchdog and final report

`timescale 1ns/1ps
`default_nettype none

module flow_xbar_tb
  import flow_xbar_pkg::*;
();

  localparam int num_phases   = 7;
  localparam int stall_cycles = 10;
  localparam logic [1:0] ready_always = 2'd0;
  localparam logic [1:0] ready_stall  = 2'd1;
  localparam logic [1:0] ready_random = 2'd2;

  // dests holds the destination of source i at bits [2i+1:2i]
  typedef struct packed {
    logic [num_push_flows-1:0]               mask;
    logic [num_push_flows*dest_id_width-1:0] dests;
    int                                      count;
    logic [1:0]                              mode;
  } phase_row_t;

  logic                                         clk;
  logic                                         rst_n;
  logic [num_push_flows-1:0]                    push_valid;
  logic [num_push_flows-1:0][data_width-1:0]    push_data;
  logic [num_push_flows-1:0][dest_id_width-1:0] push_dest_id;
  logic [num_push_flows-1:0]                    push_ready;
  logic [num_pop_flows-1:0]                     pop_valid;
  logic [num_pop_flows-1:0][data_width-1:0]     pop_data;
  logic [num_pop_flows-1:0]                     pop_ready;
  logic                                         end_of_test;
  int                                           checker_errors;
  int                                           errors = 0;
  int                                           watchdog_cycles = 0;
  integer                                       seed = 32'hccbc_3a64;
  phase_row_t                                   phase_table [num_phases];

  flow_xbar_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

  flow_xbar dut (
    .clk(clk), .rst_n(rst_n),
    .push_valid(push_valid), .push_data(push_data), .push_dest_id(push_dest_id),
    .push_ready(push_ready),
    .pop_valid(pop_valid), .pop_data(pop_data), .pop_ready(pop_ready)
  );

  flow_xbar_checker u_checker (
    .clk(clk), .rst_n(rst_n),
    .push_valid(push_valid), .push_data(push_data), .push_dest_id(push_dest_id),
    .push_ready(push_ready),
    .pop_valid(pop_valid), .pop_data(pop_data), .pop_ready(pop_ready),
    .end_of_test(end_of_test), .error_count(checker_errors)
  );

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: words still in flight after %0d cycles", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    phase_row_t row;
    int to_send [num_push_flows];
    int phase_words;
    int accepted;
    int popped;
    int phase_cycle;
    int cycle_count;
    logic latency_row;
    logic fair_row;
    logic [31:0] rnd;
    logic [num_push_flows-1:0] fire;
    logic [num_pop_flows-1:0] pops;
    logic [num_push_flows-1:0] seen;
    int accept_cycle [$];
    int fair_order [$];
    push_valid   = '0;
    push_data    = '0;
    push_dest_id = '0;
    pop_ready    = '0;
    end_of_test  = 1'b0;
    cycle_count  = 0;
    // single word, single stream, routing, contention, stall, random back-pressure
    phase_table[0] = '{4'b0001, 8'h01, 1, ready_always};
    phase_table[1] = '{4'b0100, 8'h30, 6, ready_always};
    phase_table[2] = '{4'b1111, 8'h1b, 8, ready_always};
    phase_table[3] = '{4'b1111, 8'haa, 12, ready_always};
    phase_table[4] = '{4'b1111, 8'h00, 10, ready_stall};
    phase_table[5] = '{4'b1011, 8'hc5, 16, ready_random};
    phase_table[6] = '{4'b1111, 8'hf0, 20, ready_random};
    phase_words = 0;
    for (int p = 0; p < num_phases; p++) begin
      phase_words += phase_table[p].count * $countones(phase_table[p].mask);
    end
    watchdog_cycles = phase_words * 12 + 200;

    wait (rst_n === 1'b1);
    @(posedge clk);
    if (pop_valid !== '0 || push_ready !== '1) begin
      $display("Fail at %0t: after reset pop_valid %b push_ready %b, expected 0000 and 1111",
               $time, pop_valid, push_ready);
      errors++;
    end

    for (int p = 0; p < num_phases; p++) begin
      row = phase_table[p];
      phase_words = row.count * $countones(row.mask);
      latency_row = ($countones(row.mask) == 1) && (row.mode == ready_always);
      fair_row = (row.mask == '1) && (row.mode == ready_always) &&
                 (row.dests == {num_push_flows{row.dests[dest_id_width-1:0]}});
      for (int i = 0; i < num_push_flows; i++) begin
        to_send[i] = row.mask[i] ? row.count : 0;
      end
      accepted = 0;
      popped = 0;
      phase_cycle = 0;
      accept_cycle.delete();
      fair_order.delete();
      while (accepted < phase_words || popped < phase_words) begin
        @(posedge clk);
        cycle_count++;
        fire = push_valid & push_ready;
        pops = pop_valid & pop_ready;
        accepted += $countones(fire);
        popped += $countones(pops);
        if (latency_row && |fire) begin
          accept_cycle.push_back(cycle_count);
        end
        for (int j = 0; j < num_pop_flows; j++) begin
          if (pops[j] && latency_row && accept_cycle.size() > 0) begin
            if (cycle_count - accept_cycle[0] != pipe_latency) begin
              $display("Fail at %0t: word popped %0d cycles after accept, expected %0d",
                       $time, cycle_count - accept_cycle[0], pipe_latency);
              errors++;
            end
            accept_cycle.delete(0);
          end
          if (pops[j] && fair_row) begin
            fair_order.push_back(int'(pop_data[j][src_id_width-1:0]));
          end
        end
        // hold a waiting word and present the next one after a transfer
        for (int i = 0; i < num_push_flows; i++) begin
          if (fire[i] || !push_valid[i]) begin
            if (to_send[i] > 0) begin
              rnd = $random(seed);
              push_valid[i]   <= 1'b1;
              push_data[i]    <= {rnd[data_width-1:src_id_width], src_id_width'(i)};
              push_dest_id[i] <= row.dests[dest_id_width*i +: dest_id_width];
              to_send[i]--;
            end else begin
              push_valid[i] <= 1'b0;
            end
          end
        end
        rnd = $random(seed);
        if (row.mode == ready_random) begin
          pop_ready <= rnd[num_pop_flows-1:0];
        end else if (row.mode == ready_stall && phase_cycle < stall_cycles) begin
          pop_ready <= '0;
        end else begin
          pop_ready <= '1;
        end
        phase_cycle++;
      end
      // four constant requesters rotate through every window of four pops
      for (int w = 0; fair_row && w + num_push_flows <= fair_order.size(); w++) begin
        seen = '0;
        for (int k = 0; k < num_push_flows; k++) begin
          seen[fair_order[w+k]] = 1'b1;
        end
        if (seen != '1) begin
          $display("Fail at %0t: pop window %0d held sources %b, expected all four",
                   $time, w, seen);
          errors++;
        end
      end
    end

    end_of_test <= 1'b1;
    repeat (2) @(posedge clk);
    $display("errors: testbench %0d, checker %0d", errors, checker_errors);
    if (errors == 0 && checker_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : flow_xbar_tb

`default_nettype wire

// File: verification/flow_xbar_checker.sv
// scoreboard monitor for the flow crossbar
// per source/destination order queues, pop stall stability, lost word report

`timescale 1ns/1ps
`default_nettype none

module flow_xbar_checker
  import flow_xbar_pkg::*;
(
  input  wire logic                                         clk,
  input  wire logic                                         rst_n,
  input  wire logic [num_push_flows-1:0]                    push_valid,
  input  wire logic [num_push_flows-1:0][data_width-1:0]    push_data,
  input  wire logic [num_push_flows-1:0][dest_id_width-1:0] push_dest_id,
  input  wire logic [num_push_flows-1:0]                    push_ready,
  input  wire logic [num_pop_flows-1:0]                     pop_valid,
  input  wire logic [num_pop_flows-1:0][data_width-1:0]     pop_data,
  input  wire logic [num_pop_flows-1:0]                     pop_ready,
  input  wire logic                                         end_of_test,
  output int                                                error_count
);

  localparam int num_pairs = num_push_flows * num_pop_flows;

  // indexed src * num_pop_flows + dest
  logic [data_width-1:0]                    expect_q [num_pairs][$];
  logic [num_pop_flows-1:0]                 stalled_q;
  logic [num_pop_flows-1:0][data_width-1:0] stalled_data_q;
  logic                                     lost_checked = 1'b0;
  int                                       errors = 0;

  assign error_count = errors;

  always @(posedge clk) begin
    int pair;
    logic [data_width-1:0] expected;
    if (!rst_n) begin
      stalled_q <= '0;
    end else begin
      for (int j = 0; j < num_pop_flows; j++) begin
        // a stalled output must not move
        if (stalled_q[j] && (!pop_valid[j] || pop_data[j] !== stalled_data_q[j])) begin
          $display("Fail at %0t: pop %0d changed while stalled, valid %b data %h, held %h",
                   $time, j, pop_valid[j], pop_data[j], stalled_data_q[j]);
          errors++;
        end
        if (pop_valid[j] && pop_ready[j]) begin
          // low data bits name the source
          pair = int'(pop_data[j][src_id_width-1:0]) * num_pop_flows + j;
          if (expect_q[pair].size() == 0) begin
            $display("unexpected word %h popped on pop %0d at time %0t", pop_data[j], j, $time);
            errors++;
          end else begin
            expected = expect_q[pair].pop_front();
            if (pop_data[j] !== expected) begin
              $display("Fail at %0t: pop %0d got %h, expected %h",
                       $time, j, pop_data[j], expected);
              errors++;
            end
          end
        end
      end
      for (int i = 0; i < num_push_flows; i++) begin
        if (push_valid[i] && push_ready[i]) begin
          pair = i * num_pop_flows + int'(push_dest_id[i]);
          expect_q[pair].push_back(push_data[i]);
        end
      end
      stalled_q <= pop_valid & ~pop_ready;
      // anything still queued here never reached its pop port
      if (end_of_test && !lost_checked) begin
        lost_checked <= 1'b1;
        for (int k = 0; k < num_pairs; k++) begin
          if (expect_q[k].size() != 0) begin
            $display("lost: %0d words from push %0d to pop %0d never arrived",
                     expect_q[k].size(), k / num_pop_flows, k % num_pop_flows);
            errors += expect_q[k].size();
          end
        end
      end
    end
    stalled_data_q <= pop_data;
  end

endmodule : flow_xbar_checker

`default_nettype wire

// File: verification/flow_xbar_clock_gen.sv
// testbench clock and reset source
// 4 ns clock, rst_n held low for the first 3 rising edges

`timescale 1ns/1ps
`default_nettype none

module flow_xbar_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // synchronous release after the third edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : flow_xbar_clock_gen

`default_nettype wire

// File: source/flow_xbar.sv
// top of the 4x4 flow crossbar
// demux stages and pop ports with transposed request and grant wiring

`timescale 1ns/1ps
`default_nettype none

module flow_xbar
  import flow_xbar_pkg::*;
(
  input  wire logic                                         clk,
  input  wire logic                                         rst_n,

  input  wire logic [num_push_flows-1:0]                    push_valid,
  input  wire logic [num_push_flows-1:0][data_width-1:0]    push_data,
  input  wire logic [num_push_flows-1:0][dest_id_width-1:0] push_dest_id,
  output logic [num_push_flows-1:0]                         push_ready,

  output logic [num_pop_flows-1:0]                          pop_valid,
  output logic [num_pop_flows-1:0][data_width-1:0]          pop_data,
  input  wire logic [num_pop_flows-1:0]                     pop_ready
);

  // indexed [push][pop] on the demux side
  logic [num_push_flows-1:0][num_pop_flows-1:0] demux_request;
  logic [num_push_flows-1:0][num_pop_flows-1:0] demux_grant;
  logic [num_push_flows-1:0][data_width-1:0]    demux_data;

  // indexed [pop][push] on the pop port side
  logic [num_pop_flows-1:0][num_push_flows-1:0] port_request;
  logic [num_pop_flows-1:0][num_push_flows-1:0] port_grant;

  for (genvar i = 0; i < num_push_flows; i++) begin : gen_transpose_push
    for (genvar j = 0; j < num_pop_flows; j++) begin : gen_transpose_pop
      assign port_request[j][i] = demux_request[i][j];
      assign demux_grant[i][j]  = port_grant[j][i];
    end
  end

  for (genvar i = 0; i < num_push_flows; i++) begin : gen_demux
    flow_xbar_demux_stage u_demux_stage (
      .clk          (clk),
      .rst_n        (rst_n),
      .push_valid   (push_valid[i]),
      .push_data    (push_data[i]),
      .push_dest_id (push_dest_id[i]),
      .push_ready   (push_ready[i]),
      .grant        (demux_grant[i]),
      .request      (demux_request[i]),
      .held_data    (demux_data[i])
    );
  end

  // every pop port sees all held words and its grant picks one
  for (genvar j = 0; j < num_pop_flows; j++) begin : gen_pop
    flow_xbar_pop_port u_pop_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .request   (port_request[j]),
      .held_data (demux_data),
      .grant     (port_grant[j]),
      .pop_valid (pop_valid[j]),
      .pop_data  (pop_data[j]),
      .pop_ready (pop_ready[j])
    );
  end

endmodule : flow_xbar

`default_nettype wire

// File: source/flow_xbar_pop_port.sv
// arbitration among push flows, data mux and output register for one pop flow
// output holds valid and data stable while pop_ready is low

`timescale 1ns/1ps
`default_nettype none

module flow_xbar_pop_port
  import flow_xbar_pkg::*;
(
  input  wire logic                                      clk,
  input  wire logic                                      rst_n,

  // this port's request bit from each demux stage
  input  wire logic [num_push_flows-1:0]                 request,
  input  wire logic [num_push_flows-1:0][data_width-1:0] held_data,
  output logic [num_push_flows-1:0]                      grant,

  output logic                                           pop_valid,
  output logic [data_width-1:0]                          pop_data,
  input  wire logic                                      pop_ready
);

  logic                      out_valid_q;
  logic [data_width-1:0]     out_data_q;
  logic                      can_load;
  logic [num_push_flows-1:0] masked_request;
  logic                      any_grant;
  logic [data_width-1:0]     mux_data;

  // output register is free, or it is drained this cycle
  assign can_load = !out_valid_q || pop_ready;

  // no grant at all while stalled, so the demux stages keep their words
  assign masked_request = can_load ? request : '0;

  flow_xbar_rr_arbiter u_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .request (masked_request),
    .advance (can_load),
    .grant   (grant)
  );

  assign any_grant = |grant;

  // and-or mux over a one-hot or zero grant
  always_comb begin
    mux_data = '0;
    for (int k = 0; k < num_push_flows; k++) begin
      if (grant[k]) begin
        mux_data = mux_data | held_data[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (can_load) begin
      out_valid_q <= any_grant;
    end
  end

  // load only on a granted transfer
  always_ff @(posedge clk) begin
    if (can_load && any_grant) begin
      out_data_q <= mux_data;
    end
  end

  assign pop_valid = out_valid_q;
  assign pop_data  = out_data_q;

endmodule : flow_xbar_pop_port

`default_nettype wire

// File: source/flow_xbar_rr_arbiter.sv
// round-robin arbiter over the push flows
// combinational grant and a priority pointer that moves past the winner on advance

`timescale 1ns/1ps
`default_nettype none

module flow_xbar_rr_arbiter
  import flow_xbar_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic [num_push_flows-1:0] request,
  input  wire logic                      advance,
  output logic [num_push_flows-1:0]      grant
);

  logic [src_id_width-1:0] ptr_q;
  logic [src_id_width-1:0] winner;
  logic                    found;

  // search upward from the pointer with wrap-around
  always_comb begin
    int idx;
    grant  = '0;
    winner = ptr_q;
    found  = 1'b0;
    for (int k = 0; k < num_push_flows; k++) begin
      idx = (int'(ptr_q) + k) % num_push_flows;
      if (!found && request[idx]) begin
        found  = 1'b1;
        winner = src_id_width'(idx);
      end
    end
    if (found) begin
      grant[winner] = 1'b1;
    end
  end

  // winner gets lowest priority next time
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (advance && found) begin
      if (winner == src_id_width'(num_push_flows - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= winner + 1'b1;
      end
    end
  end

endmodule : flow_xbar_rr_arbiter

`default_nettype wire

// File: source/flow_xbar_demux_stage.sv
// one-entry push register with one-hot destination request
// full throughput when the held word is granted in the same cycle

`timescale 1ns/1ps
`default_nettype none

module flow_xbar_demux_stage
  import flow_xbar_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  input  wire logic                     push_valid,
  input  wire logic [data_width-1:0]    push_data,
  input  wire logic [dest_id_width-1:0] push_dest_id,
  output logic                          push_ready,

  input  wire logic [num_pop_flows-1:0] grant,
  output logic [num_pop_flows-1:0]      request,
  output logic [data_width-1:0]         held_data
);

  logic [num_pop_flows-1:0] request_q;
  logic [num_pop_flows-1:0] dest_onehot;
  logic [data_width-1:0]    data_q;
  logic                     entry_valid;
  logic                     entry_leaving;
  logic                     push_fire;

  // the register holds a word whenever any request bit is set
  assign entry_valid   = |request_q;
  assign entry_leaving = |grant;

  // accept when empty or when the current word leaves this cycle
  assign push_ready = !entry_valid || entry_leaving;
  assign push_fire  = push_valid && push_ready;

  // destination decode happens here and nowhere else
  always_comb begin
    dest_onehot = '0;
    dest_onehot[push_dest_id] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      request_q <= '0;
    end else if (push_fire) begin
      request_q <= dest_onehot;
    end else if (entry_leaving) begin
      request_q <= '0;
    end
  end

  // held payload, loaded on every accepted push
  always_ff @(posedge clk) begin
    if (push_fire) begin
      data_q <= push_data;
    end
  end

  assign request   = request_q;
  assign held_data = data_q;

endmodule : flow_xbar_demux_stage

`default_nettype wire

// File: source/flow_xbar_pkg.sv
// shared sizes and pipeline constants for the 4x4 flow crossbar
// flow counts, data and id widths, free-path latency

`default_nettype none

package flow_xbar_pkg;

  // number of push (source) flows
  localparam int num_push_flows = 4;

  // number of pop (destination) flows
  localparam int num_pop_flows = 4;

  // payload width of one word
  localparam int data_width = 16;

  // selects one of num_pop_flows
  localparam int dest_id_width = 2;

  // selects one of num_push_flows and sizes the arbiter pointer
  localparam int src_id_width = 2;

  // one register after the demux plus one at the pop output
  // counted from the push accept edge to pop_valid with a free path
  localparam int pipe_latency = 2;

endpackage : flow_xbar_pkg

`default_nettype wire
